//--- common/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;
    localparam int nregs = 32;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [31:0]     instr_t;
    typedef logic [9:0]      funct_t;    // {funct7, funct3}.

    localparam xlen_t reset_pc = 32'h0000_0000;

    // major opcodes handled by this slice.
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;   // operand b from imm.
        logic    alu_src_pc;    // operand a from pc.
        logic    reg_write;
        logic    jump;
        logic    jalr;
        logic    branch;
        logic    valid;         // low for a bubble.
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        xlen_t     rs1_data;
        xlen_t     rs2_data;
        xlen_t     pc;
        xlen_t     pc_plus4;
        xlen_t     pc_imm;      // branch or jal target.
        xlen_t     imm;         // operand b immediate.
        funct_t    funct;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      we;
        reg_addr_t rd;
        xlen_t     data;
    } retire_t;

endpackage

//--- decode/rv_decoder.sv
module rv_decoder
    import rv_pkg::*;
(
    input  logic   instr_valid_i,
    input  xlen_t  pc_i,
    input  instr_t instr_i,
    output id_ex_t dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i_type;
    xlen_t      imm_u_type;
    xlen_t      imm_b_type;
    xlen_t      imm_j_type;
    xlen_t      imm;
    xlen_t      pc_imm;
    alu_op_e    alu_f3;
    ctrl_t      ctrl;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

    // jal uses the j immediate, branches the b immediate.
    assign pc_imm = pc_i + ((opcode == OP_JAL) ? imm_j_type : imm_b_type);

    // shared by register and immediate forms.
    always_comb begin
        case (funct3)
            3'b000:  alu_f3 = (opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_f3 = ALU_SLL;
            3'b010:  alu_f3 = ALU_SLT;
            3'b011:  alu_f3 = ALU_SLTU;
            3'b100:  alu_f3 = ALU_XOR;
            3'b101:  alu_f3 = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_f3 = ALU_OR;
            default: alu_f3 = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = ALU_ADD;
        imm = imm_i_type;
        case (opcode)
            OP_REG: begin
                ctrl.alu_op = alu_f3;
                ctrl.reg_write = 1'b1;
            end
            OP_IMM: begin
                ctrl.alu_op = alu_f3;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_LUI: begin
                ctrl.alu_op = ALU_PASS_B;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                imm = imm_u_type;
            end
            OP_AUIPC: begin
                ctrl.alu_src_pc = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                imm = imm_u_type;
            end
            OP_JAL: begin
                ctrl.jump = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_JALR: begin
                ctrl.jalr = 1'b1;
                ctrl.alu_src_imm = 1'b1;    // alu forms rs1 + imm.
                ctrl.reg_write = 1'b1;
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
            end
            default: ;                      // retires with no effect.
        endcase
        ctrl.valid = 1'b1;
        if (!instr_valid_i) begin
            ctrl = '0;
        end
    end

    always_comb begin
        dec_o = '0;
        dec_o.ctrl = ctrl;
        dec_o.pc = pc_i;
        dec_o.pc_plus4 = pc_i + 32'd4;
        dec_o.pc_imm = pc_imm;
        dec_o.imm = imm;
        dec_o.funct = {funct7, funct3};
        dec_o.rs1_addr = instr_i[19:15];
        dec_o.rs2_addr = instr_i[24:20];
        dec_o.rd_addr = instr_i[11:7];
    end

endmodule

//--- decode/rv_regfile.sv
module rv_regfile
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    input  retire_t   wr_i
);

    xlen_t regs [1:nregs-1];    // x0 has no storage.
    logic  wr_en;

    assign wr_en = wr_i.valid && wr_i.we && (wr_i.rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_i.rd] <= wr_i.data;
        end
    end

    // write-through, so decode sees the value retiring this cycle.
    function automatic xlen_t read_port(input reg_addr_t addr);
        xlen_t val;
        if (addr == '0) begin
            val = '0;
        end else if (wr_en && (wr_i.rd == addr)) begin
            val = wr_i.data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

//--- source/rv_id_ex.sv
module rv_id_ex
    import rv_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   hold_i,
    input  logic   flush_i,
    input  id_ex_t d_i,
    output id_ex_t q_o
);

    id_ex_t q;

    // priority is reset, hold, flush, then load.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= '0;
        end else if (hold_i) begin
            q <= q;
        end else if (flush_i) begin
            q <= '0;        // ctrl.valid low, so a bubble moves on.
        end else begin
            q <= d_i;
        end
    end

    assign q_o = q;

endmodule

//--- execute/rv_execute.sv
module rv_execute
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    hold_i,
    input  id_ex_t  ex_i,
    output retire_t retire_o,
    output logic    redirect_o,
    output xlen_t   redirect_pc_o
);

    retire_t    retire_q;
    retire_t    retire_d;
    logic       fwd_rs1;
    logic       fwd_rs2;
    xlen_t      rs1_val;
    xlen_t      rs2_val;
    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      alu_res;
    logic [2:0] br_funct3;
    logic       taken;
    logic       transfer;

    // the instruction one stage ahead is still in the retire register.
    assign fwd_rs1 = retire_q.valid && retire_q.we && (retire_q.rd != '0) &&
                     (retire_q.rd == ex_i.rs1_addr);
    assign fwd_rs2 = retire_q.valid && retire_q.we && (retire_q.rd != '0) &&
                     (retire_q.rd == ex_i.rs2_addr);

    assign rs1_val = fwd_rs1 ? retire_q.data : ex_i.rs1_data;
    assign rs2_val = fwd_rs2 ? retire_q.data : ex_i.rs2_data;

    assign op_a = ex_i.ctrl.alu_src_pc ? ex_i.pc : rs1_val;
    assign op_b = ex_i.ctrl.alu_src_imm ? ex_i.imm : rs2_val;

    always_comb begin
        case (ex_i.ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    assign br_funct3 = ex_i.funct[2:0];

    always_comb begin
        case (br_funct3)
            3'b000:  taken = (rs1_val == rs2_val);
            3'b001:  taken = (rs1_val != rs2_val);
            3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));
            3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            3'b110:  taken = (rs1_val < rs2_val);
            3'b111:  taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign transfer = ex_i.ctrl.valid &&
                      (ex_i.ctrl.jump || ex_i.ctrl.jalr || (ex_i.ctrl.branch && taken));

    // one pulse per transfer, not repeated while held.
    assign redirect_o = transfer && !hold_i;
    assign redirect_pc_o = ex_i.ctrl.jalr ? {alu_res[31:1], 1'b0} : ex_i.pc_imm;

    always_comb begin
        retire_d.valid = ex_i.ctrl.valid;
        retire_d.we = ex_i.ctrl.valid && ex_i.ctrl.reg_write && (ex_i.rd_addr != '0);
        retire_d.rd = ex_i.rd_addr;
        retire_d.data = (ex_i.ctrl.jump || ex_i.ctrl.jalr) ? ex_i.pc_plus4 : alu_res;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_q <= '0;
        end else if (!hold_i) begin
            retire_q <= retire_d;
        end
    end

    assign retire_o = retire_q;

endmodule

//--- source/rv_dx_top.sv
module rv_dx_top
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid_i,
    input  xlen_t     pc_i,
    input  instr_t    instr_i,
    input  logic      hold_i,
    output logic      retire_valid_o,
    output logic      retire_we_o,
    output reg_addr_t retire_rd_o,
    output xlen_t     retire_data_o,
    output logic      redirect_o,
    output xlen_t     redirect_pc_o
);

    id_ex_t  dec;
    id_ex_t  id_d;
    id_ex_t  id_q;
    xlen_t   rs1_data;
    xlen_t   rs2_data;
    retire_t retire;
    logic    redirect;

    rv_decoder u_decoder (
        .instr_valid_i (instr_valid_i),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .dec_o         (dec)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (dec.rs1_addr),
        .rs2_addr_i (dec.rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (retire)
    );

    always_comb begin
        id_d = dec;
        id_d.rs1_data = rs1_data;
        id_d.rs2_data = rs2_data;
    end

    rv_id_ex u_id_ex (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold_i  (hold_i),
        .flush_i (redirect),    // drops the instruction in decode.
        .d_i     (id_d),
        .q_o     (id_q)
    );

    rv_execute u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .hold_i        (hold_i),
        .ex_i          (id_q),
        .retire_o      (retire),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc_o)
    );

    assign retire_valid_o = retire.valid;
    assign retire_we_o = retire.we;
    assign retire_rd_o = retire.rd;
    assign retire_data_o = retire.data;
    assign redirect_o = redirect;

endmodule

//--- testbench/rv_dx_asserts.sv
module rv_dx_asserts
    import rv_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      hold_i,
    input logic      retire_valid_i,
    input logic      retire_we_i,
    input reg_addr_t retire_rd_i,
    input xlen_t     retire_data_i,
    input logic      redirect_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // a held edge leaves the retire register untouched.
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        hold_i |=> $stable({retire_valid_i, retire_we_i, retire_rd_i, retire_data_i}))
        else $error("retire outputs changed across a held cycle");

    a_no_redirect_in_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> !redirect_i)
        else $error("redirect high during reset");

    // reset leaves nothing to retire.
    a_reset_clears: assert property (@(posedge clk)
        $rose(rst_n) |-> !retire_valid_i)
        else $error("retire valid right after reset");

endmodule

bind rv_dx_top rv_dx_asserts u_asserts (
    .clk            (clk),
    .rst_n          (rst_n),
    .hold_i         (hold_i),
    .retire_valid_i (retire_valid_o),
    .retire_we_i    (retire_we_o),
    .retire_rd_i    (retire_rd_o),
    .retire_data_i  (retire_data_o),
    .redirect_i     (redirect_o)
);

//--- testbench/rv_dx_tb.sv
module rv_dx_tb
    import rv_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int prog_base = 0;
    localparam int count_base = 40;   // retire count, redirect count.
    localparam int ret_base = 48;     // two words per record.
    localparam int red_base = 96;

    logic      clk;
    logic      rst_n;
    logic      instr_valid;
    xlen_t     pc_drv;
    instr_t    instr_drv;
    logic      hold;
    logic      retire_valid;
    logic      retire_we;
    reg_addr_t retire_rd;
    xlen_t     retire_data;
    logic      redirect;
    xlen_t     redirect_pc;

    logic [31:0] pat [0:127];
    logic [31:0] seed;
    xlen_t       fetch_pc;
    int          n_ret;
    int          n_red;
    int          ret_idx;
    int          red_idx;
    logic        held;
    logic        last_hold;
    logic        loaded;

    rv_dx_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid_i  (instr_valid),
        .pc_i           (pc_drv),
        .instr_i        (instr_drv),
        .hold_i         (hold),
        .retire_valid_o (retire_valid),
        .retire_we_o    (retire_we),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic fail_run(input string why);
        $display("%s at %0t", why, $time);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // new gap and hold draws; a held fetch keeps its instruction.
    task automatic drive_fetch();
        seed = lcg_next(seed);
        hold = (seed[23:22] == 2'b00);
        if (!held) begin
            instr_valid = (seed[27:25] != 3'b000);
            pc_drv = fetch_pc;
            instr_drv = pat[prog_base + int'(fetch_pc[7:2])];
        end
    endtask

    task automatic check_retire();
        logic [31:0] rec;
        if (ret_idx >= n_ret) begin
            fail_run("an instruction retired after the expected list ended");
        end else begin
            rec = pat[ret_base + 2 * ret_idx];
            check_value("retire_we_o", {31'b0, retire_we}, {31'b0, rec[8]});
            if (rec[8]) begin
                check_value("retire_rd_o", {27'b0, retire_rd}, {27'b0, rec[4:0]});
                check_value("retire_data_o", retire_data, pat[ret_base + 2 * ret_idx + 1]);
            end
            ret_idx++;
        end
    endtask

    task automatic check_redirect();
        if (red_idx >= n_red) begin
            fail_run("a redirect arrived after the expected list ended");
        end else begin
            check_value("redirect_pc_o", redirect_pc, pat[red_base + red_idx]);
            red_idx++;
        end
    endtask

    // sampled at the falling edge, where all outputs are settled.
    task automatic observe_cycle();
        if (!last_hold && retire_valid) begin
            check_retire();
        end
        if (redirect) begin
            check_redirect();
        end
        held = hold;
        if (!hold) begin
            if (redirect) begin
                fetch_pc = redirect_pc;       // drops the word in decode.
            end else if (instr_valid) begin
                fetch_pc = fetch_pc + 32'd4;
            end
        end
        last_hold = hold;
    endtask

    initial begin
        loaded = 1'b0;
        for (int i = 0; i < 128; i++) begin
            pat[i] = '0;
        end
        $readmemh("testbench/rv_dx_patterns.txt", pat);
        n_ret = int'(pat[count_base]);
        n_red = int'(pat[count_base + 1]);
        loaded = 1'b1;
    end

    initial begin
        wait (loaded);
        repeat (n_ret * 40 + 10) @(posedge clk);
        fail_run("watchdog expired before all retirements arrived");
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        pc_drv = '0;
        instr_drv = '0;
        hold = 1'b0;
        seed = 32'd93;
        fetch_pc = reset_pc;
        ret_idx = 0;
        red_idx = 0;
        held = 1'b0;
        last_hold = 1'b0;
        wait (loaded);
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        drive_fetch();
        @(negedge clk);
        check_value("retire_valid_o", {31'b0, retire_valid}, 32'd0);
        check_value("redirect_o", {31'b0, redirect}, 32'd0);
        observe_cycle();
        while (ret_idx < n_ret) begin
            @(posedge clk);
            #1;
            drive_fetch();
            @(negedge clk);
            observe_cycle();
        end
        check_value("redirect count", red_idx, n_red);
        $display("TEST OK");
        $finish;
    end

endmodule

//--- rv_dx.f
common/rv_pkg.sv
decode/rv_decoder.sv
decode/rv_regfile.sv
source/rv_id_ex.sv
execute/rv_execute.sv
source/rv_dx_top.sv
testbench/rv_dx_asserts.sv
testbench/rv_dx_tb.sv

//--- run.sh
#!/bin/sh
# Builds the decode/execute slice with Verilator and runs its testbench.
set -e
cd "$(dirname "$0")"

rm -rf build
verilator --binary --timing --assert \
    --top-module rv_dx_tb \
    -f rv_dx.f \
    --Mdir build -o rv_dx_sim

# the simulator exits nonzero on $fatal, the log decides the result
./build/rv_dx_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST OK" sim.log; then
    exit 0
else
    exit 1
fi

//--- testbench/rv_dx_patterns.txt
// program words at word address pc/4, then at 0x28 the retire and redirect counts,
// at 0x30 retire records as {we at bit 8, rd} then data, at 0x60 redirect targets.
@00
00500093 // 00 addi x1, x0, 5
00308113 // 04 addi x2, x1, 3
002081B3 // 08 add  x3, x1, x2
40118233 // 0c sub  x4, x3, x1
00221293 // 10 slli x5, x4, 2
12345337 // 14 lui  x6, 0x12345
00001397 // 18 auipc x7, 1
00410463 // 1c beq  x2, x4, +8 taken
06300413 // 20 wrong path
00109463 // 24 bne  x1, x1, +8 not taken
00C004EF // 28 jal  x9, +12
00100413 // 2c wrong path
00200413 // 30 wrong path
04000513 // 34 addi x10, x0, 0x40
004505E7 // 38 jalr x11, 4(x10)
00300413 // 3c wrong path
00400413 // 40 wrong path
00708013 // 44 addi x0, x1, 7
00100633 // 48 add  x12, x0, x1
FFF00713 // 4c addi x14, x0, -1
00E0B6B3 // 50 sltu x13, x1, x14
40475793 // 54 srai x15, x14, 4
00E0D463 // 58 bge  x1, x14, +8 taken
00500413 // 5c wrong path
0000006F // 60 jal  x0, 0
@28
00000013 00000005
@30
00000101 00000005
00000102 00000008
00000103 0000000D
00000104 00000008
00000105 00000020
00000106 12345000
00000107 00001018
00000000 00000000
00000000 00000000
00000109 0000002C
0000010A 00000040
0000010B 0000003C
00000000 00000000
0000010C 00000005
0000010E FFFFFFFF
0000010D 00000001
0000010F FFFFFFFF
00000000 00000000
00000000 00000000
@60
00000024
00000034
00000044
00000060
00000060
